/* Bender.yml */
package:
  name: alu

sources:
  # packages first, the data package refers to the operator package
  - design/alu_op_pkg.sv
  - design/alu_data_pkg.sv
  # combinational datapath
  - design/alu_adder.sv
  - design/alu_shifter.sv
  - design/alu_compare.sv
  - design/alu_core.sv
  # handshake and top level
  - design/alu_req_ack.sv
  - design/alu_top.sv
  # testbench
  - target: test
    files:
      - testbench/alu_props.sv
      - testbench/alu_tb.sv

/* alu.f */
design/alu_op_pkg.sv
design/alu_data_pkg.sv
design/alu_adder.sv
design/alu_shifter.sv
design/alu_compare.sv
design/alu_core.sv
design/alu_req_ack.sv
design/alu_top.sv
testbench/alu_props.sv
testbench/alu_tb.sv

/* design/alu_adder.sv */
// alu_adder
// byte-lane split adder with carry-insert bits
// optional inversion of operand a (abs) or operand b (subtract)

`timescale 1ns/10ps
`default_nettype none

module alu_adder
(
  input  alu_data_pkg::word_t operand_a_i,
  input  alu_data_pkg::word_t operand_b_i,
  input  logic                negate_a_i,
  input  logic                negate_b_i,
  output alu_data_pkg::word_t sum_o
);

  // lane width and width of the spread vector, one insert bit per lane
  localparam int LANE_W   = $bits(alu_data_pkg::lane_t);
  localparam int SPREAD_W = alu_data_pkg::NUM_LANES * (LANE_W + 1);

  alu_data_pkg::word_t   op_a;
  alu_data_pkg::word_t   op_b;
  logic [SPREAD_W-1:0]   in_a;
  logic [SPREAD_W-1:0]   in_b;
  logic [SPREAD_W-1:0]   sum_spread;

  // one's complement of the selected operand
  assign op_a = negate_a_i ? ~operand_a_i : operand_a_i;
  assign op_b = negate_b_i ? ~operand_b_i : operand_b_i;

  //////////////////////////////////////////////////////////////////////
  // spread operands into lanes
  //////////////////////////////////////////////////////////////////////

  // insert bit of a is always 1, of b always 0
  // so a carry out of a lane propagates through the insert bit
  // bottom insert bit of b carries the +1 of two's complement
  for (genvar l = 0; l < alu_data_pkg::NUM_LANES; l++)
  begin : g_lane
    assign in_a[l*(LANE_W+1)]                = 1'b1;
    assign in_a[l*(LANE_W+1)+1 +: LANE_W]    = op_a[l*LANE_W +: LANE_W];
    assign in_b[l*(LANE_W+1)+1 +: LANE_W]    = op_b[l*LANE_W +: LANE_W];
    if (l == 0)
    begin : g_cin
      // 1 + 1 at bit 0 carries into lane 0
      assign in_b[0] = negate_a_i | negate_b_i;
    end
    else
    begin : g_prop
      assign in_b[l*(LANE_W+1)] = 1'b0;
    end
    // drop the insert bit when reassembling
    assign sum_o[l*LANE_W +: LANE_W] = sum_spread[l*(LANE_W+1)+1 +: LANE_W];
  end

  // one wide adder over all lanes
  assign sum_spread = in_a + in_b;

endmodule

`default_nettype wire

/* design/alu_compare.sv */
// alu_compare
// per-lane equal and greater-than flags, top lane optionally signed
// lane chain to one word-level equal and greater flag
// min, max and abs selection

`timescale 1ns/10ps
`default_nettype none

module alu_compare
(
  input  alu_data_pkg::word_t operand_a_i,
  input  alu_data_pkg::word_t operand_b_i,
  input  alu_data_pkg::word_t negated_a_i,
  input  logic                signed_i,
  input  logic                do_min_i,
  input  logic                abs_i,
  output logic                is_equal_o,
  output logic                is_greater_o,
  output alu_data_pkg::word_t minmax_o
);

  localparam int LANE_W = $bits(alu_data_pkg::lane_t);
  localparam int TOP    = alu_data_pkg::NUM_LANES - 1;

  alu_data_pkg::word_t               cmp_b;
  alu_data_pkg::word_t               second;
  logic [alu_data_pkg::NUM_LANES-1:0] lane_eq;
  logic [alu_data_pkg::NUM_LANES-1:0] lane_gt;
  logic                              sel_a;

  // abs compares a against zero
  // and chooses between a and the adder's negated a
  assign cmp_b  = abs_i ? '0 : operand_b_i;
  assign second = abs_i ? negated_a_i : operand_b_i;

  //////////////////////////////////////////////////////////////////////
  // lane compare
  //////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < alu_data_pkg::NUM_LANES; l++)
  begin : g_lane
    alu_data_pkg::lane_t lane_a;
    alu_data_pkg::lane_t lane_b;
    logic                ext_a;
    logic                ext_b;

    assign lane_a = operand_a_i[l*LANE_W +: LANE_W];
    assign lane_b = cmp_b[l*LANE_W +: LANE_W];

    // only the top lane carries the sign
    // lower lanes always compare unsigned
    assign ext_a = (l == TOP) ? (signed_i & lane_a[LANE_W-1]) : 1'b0;
    assign ext_b = (l == TOP) ? (signed_i & lane_b[LANE_W-1]) : 1'b0;

    assign lane_eq[l] = (lane_a == lane_b);
    assign lane_gt[l] = $signed({ext_a, lane_a}) > $signed({ext_b, lane_b});
  end

  //////////////////////////////////////////////////////////////////////
  // word-level chain
  //////////////////////////////////////////////////////////////////////

  // walk from lane 0 upward
  // a higher lane decides unless its bytes are equal
  always_comb
  begin
    is_greater_o = 1'b0;
    for (int l = 0; l < alu_data_pkg::NUM_LANES; l++)
    begin
      is_greater_o = lane_gt[l] | (lane_eq[l] & is_greater_o);
    end
  end

  assign is_equal_o = &lane_eq;

  //////////////////////////////////////////////////////////////////////
  // min / max / abs
  //////////////////////////////////////////////////////////////////////

  // max keeps a when a > b, min inverts the choice
  assign sel_a    = is_greater_o ^ do_min_i;
  assign minmax_o = sel_a ? operand_a_i : second;

endmodule

`default_nettype wire

/* design/alu_core.sv */
// alu_core
// combinational ALU: operator decode, adder, shifter, compare
// comparison flag and final result mux

`timescale 1ns/10ps
`default_nettype none

module alu_core
(
  input  alu_data_pkg::alu_req_t req_i,
  output alu_data_pkg::alu_rsp_t rsp_o
);

  localparam int LANE_W  = $bits(alu_data_pkg::lane_t);
  localparam int SHAMT_W = $bits(alu_data_pkg::shamt_t);

  alu_op_pkg::alu_op_e   op;
  alu_data_pkg::word_t   a;
  alu_data_pkg::word_t   b;
  alu_data_pkg::word_t   adder_b;
  alu_data_pkg::word_t   sum;
  alu_data_pkg::word_t   shift_in;
  alu_data_pkg::shamt_t  shamt;
  alu_data_pkg::word_t   shift_result;
  alu_data_pkg::word_t   minmax;
  logic                  is_equal;
  logic                  is_greater;
  logic                  cmp_result;
  logic                  is_abs;

  assign op     = req_i.operator;
  assign a      = req_i.operand_a;
  assign b      = req_i.operand_b;
  assign is_abs = (op == alu_op_pkg::ABS);

  //////////////////////////////////////////////////////////////////////
  // datapath units
  //////////////////////////////////////////////////////////////////////

  // abs computes 0 - a
  assign adder_b = is_abs ? '0 : b;

  alu_adder u_adder
  (
    .operand_a_i (a),
    .operand_b_i (adder_b),
    .negate_a_i  (is_abs),
    .negate_b_i  (op == alu_op_pkg::SUB),
    .sum_o       (sum)
  );

  // add/sub pass the sum through the shifter unshifted
  assign shift_in = alu_op_pkg::is_addsub_op(op) ? sum : a;
  assign shamt    = alu_op_pkg::is_addsub_op(op) ? '0 : b[SHAMT_W-1:0];

  alu_shifter u_shifter
  (
    .operand_i    (shift_in),
    .shamt_i      (shamt),
    .shift_left_i (op == alu_op_pkg::SLL),
    .arithmetic_i (op == alu_op_pkg::SRA),
    .rotate_i     (op == alu_op_pkg::ROR),
    .result_o     (shift_result)
  );

  alu_compare u_compare
  (
    .operand_a_i  (a),
    .operand_b_i  (b),
    .negated_a_i  (sum),
    .signed_i     (alu_op_pkg::is_signed_op(op)),
    .do_min_i     ((op == alu_op_pkg::MIN) || (op == alu_op_pkg::MINU)),
    .abs_i        (is_abs),
    .is_equal_o   (is_equal),
    .is_greater_o (is_greater),
    .minmax_o     (minmax)
  );

  //////////////////////////////////////////////////////////////////////
  // comparison result
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (op)
      alu_op_pkg::EQ:                     cmp_result = is_equal;
      alu_op_pkg::NE:                     cmp_result = ~is_equal;
      alu_op_pkg::GTS, alu_op_pkg::GTU:   cmp_result = is_greater;
      alu_op_pkg::GES, alu_op_pkg::GEU:   cmp_result = is_greater | is_equal;
      alu_op_pkg::LTS, alu_op_pkg::LTU,
      alu_op_pkg::SLTS, alu_op_pkg::SLTU: cmp_result = ~(is_greater | is_equal);
      alu_op_pkg::LES, alu_op_pkg::LEU:   cmp_result = ~is_greater;
      default:                            cmp_result = 1'b0;
    endcase
  end

  // flag only meaningful for compares and slt
  assign rsp_o.comparison = (alu_op_pkg::is_cmp_op(op) || alu_op_pkg::is_slt_op(op)) &
                            cmp_result;

  //////////////////////////////////////////////////////////////////////
  // result mux
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    rsp_o.result = '0;
    case (op)
      alu_op_pkg::AND: rsp_o.result = a & b;
      alu_op_pkg::OR:  rsp_o.result = a | b;
      alu_op_pkg::XOR: rsp_o.result = a ^ b;
      default:
      begin
        if (alu_op_pkg::is_addsub_op(op) || alu_op_pkg::is_shift_op(op))
          rsp_o.result = shift_result;
        else if (alu_op_pkg::is_cmp_op(op))
          // flag replicated over every lane
          rsp_o.result = {alu_data_pkg::NUM_LANES{{LANE_W{cmp_result}}}};
        else if (alu_op_pkg::is_slt_op(op))
          rsp_o.result[0] = cmp_result;
        else if (alu_op_pkg::is_minmax_op(op))
          rsp_o.result = minmax;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/alu_data_pkg.sv */
// ALU data definitions
// word, byte lane and shift amount types
// request and response structs of the handshake boundary
// handshake state encoding

`default_nettype none

package alu_data_pkg;

  // one data word
  typedef logic [31:0] word_t;

  // one byte lane of a word
  typedef logic [7:0] lane_t;

  // the adder and comparator are built for exactly four lanes
  localparam int NUM_LANES = 4;

  // shift amount, low bits of operand b
  typedef logic [4:0] shamt_t;

  // request: operator plus two operands, 69 bits
  typedef struct packed
  {
    alu_op_pkg::alu_op_e operator;
    word_t               operand_a;
    word_t               operand_b;
  } alu_req_t;

  // response: result word plus comparison flag, 33 bits
  typedef struct packed
  {
    word_t result;
    logic  comparison;
  } alu_rsp_t;

  // four-phase handshake states
  typedef enum logic [1:0]
  {
    IDLE = 2'd0,
    BUSY = 2'd1,
    DONE = 2'd2
  } hs_state_e;

endpackage

`default_nettype wire

/* design/alu_op_pkg.sv */
// ALU operator definitions
// operator encoding width and the operator enum
// operator-class helper functions used by the core decoder

`default_nettype none

package alu_op_pkg;

  // width of the operator field
  localparam int ALU_OP_WIDTH = 5;

  //////////////////////////////////////////////////////////////////////
  // operator encoding
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [ALU_OP_WIDTH-1:0]
  {
    // arithmetic
    ADD  = 5'd0,  SUB  = 5'd1,  ABS  = 5'd2,
    // bitwise logic
    AND  = 5'd3,  OR   = 5'd4,  XOR  = 5'd5,
    // shifts and rotate
    SLL  = 5'd6,  SRL  = 5'd7,  SRA  = 5'd8,  ROR  = 5'd9,
    // compares, all-ones or zero word
    EQ   = 5'd10, NE   = 5'd11, GTS  = 5'd12, GTU  = 5'd13,
    GES  = 5'd14, GEU  = 5'd15, LTS  = 5'd16, LTU  = 5'd17,
    LES  = 5'd18, LEU  = 5'd19,
    // set-less-than, 0 or 1
    SLTS = 5'd20, SLTU = 5'd21,
    // min and max
    MIN  = 5'd22, MINU = 5'd23, MAX  = 5'd24, MAXU = 5'd25
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  // operator classes
  //////////////////////////////////////////////////////////////////////

  // add and sub route the adder sum through the shifter
  function automatic logic is_addsub_op(alu_op_e op);
    return (op == ADD) || (op == SUB);
  endfunction

  function automatic logic is_shift_op(alu_op_e op);
    return (op == SLL) || (op == SRL) || (op == SRA) || (op == ROR);
  endfunction

  // compares returning a full word
  function automatic logic is_cmp_op(alu_op_e op);
    return (op >= EQ) && (op <= LEU);
  endfunction

  function automatic logic is_slt_op(alu_op_e op);
    return (op == SLTS) || (op == SLTU);
  endfunction

  // result taken from the min/max selector, abs included
  function automatic logic is_minmax_op(alu_op_e op);
    return (op == ABS) || ((op >= MIN) && (op <= MAXU));
  endfunction

  // operators that compare as signed numbers
  function automatic logic is_signed_op(alu_op_e op);
    return (op == GTS) || (op == GES) || (op == LTS) || (op == LES) ||
           (op == SLTS) || (op == MIN) || (op == MAX) || (op == ABS);
  endfunction

endpackage

`default_nettype wire

/* design/alu_req_ack.sv */
// alu_req_ack
// four-phase req/ack FSM
// operand register feeding the core, result register toward the requester

`timescale 1ns/10ps
`default_nettype none

module alu_req_ack
(
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   req_i,
  input  alu_data_pkg::alu_req_t req_data_i,
  output logic                   ack_o,
  output alu_data_pkg::alu_rsp_t rsp_o,
  output alu_data_pkg::alu_req_t core_req_o,
  input  alu_data_pkg::alu_rsp_t core_rsp_i
);

  alu_data_pkg::hs_state_e state_q;
  alu_data_pkg::hs_state_e state_d;
  alu_data_pkg::alu_req_t  req_q;
  alu_data_pkg::alu_rsp_t  rsp_q;

  //////////////////////////////////////////////////////////////////////
  // handshake FSM
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      // wait for a new request
      alu_data_pkg::IDLE: if (req_i) state_d = alu_data_pkg::BUSY;
      // core settles for one full cycle
      alu_data_pkg::BUSY: state_d = alu_data_pkg::DONE;
      // hold ack until the requester withdraws
      alu_data_pkg::DONE: if (!req_i) state_d = alu_data_pkg::IDLE;
      default:            state_d = alu_data_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      state_q <= alu_data_pkg::IDLE;
    else
      state_q <= state_d;
  end

  //////////////////////////////////////////////////////////////////////
  // data registers
  //////////////////////////////////////////////////////////////////////

  // operands latched on the capture edge
  always_ff @(posedge clk)
  begin
    if ((state_q == alu_data_pkg::IDLE) && req_i)
      req_q <= req_data_i;
  end

  // result latched as ack rises, then held through DONE
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      rsp_q <= '0;
    else if (state_q == alu_data_pkg::BUSY)
      rsp_q <= core_rsp_i;
  end

  assign core_req_o = req_q;
  assign rsp_o      = rsp_q;
  assign ack_o      = (state_q == alu_data_pkg::DONE);

endmodule

`default_nettype wire

/* design/alu_shifter.sv */
// alu_shifter
// single right shifter with bit reversal for left shifts
// logical, arithmetic and rotate modes

`timescale 1ns/10ps
`default_nettype none

module alu_shifter
(
  input  alu_data_pkg::word_t  operand_i,
  input  alu_data_pkg::shamt_t shamt_i,
  input  logic                 shift_left_i,
  input  logic                 arithmetic_i,
  input  logic                 rotate_i,
  output alu_data_pkg::word_t  result_o
);

  localparam int WORD_W = $bits(alu_data_pkg::word_t);

  alu_data_pkg::word_t   operand_rev;
  alu_data_pkg::word_t   shift_in;
  logic [2*WORD_W-1:0]   shift_src;
  logic [2*WORD_W-1:0]   shift_wide;
  alu_data_pkg::word_t   shift_right;
  alu_data_pkg::word_t   shift_right_rev;
  logic                  fill_bit;

  //////////////////////////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////////////////////////

  // left shift = reverse, shift right, reverse back
  assign operand_rev = {<<{operand_i}};
  assign shift_in    = shift_left_i ? operand_rev : operand_i;

  // sign fill only for arithmetic right shifts
  assign fill_bit = arithmetic_i & shift_in[WORD_W-1];

  // upper half feeds the vacated bits
  // rotate refills with the word itself
  assign shift_src = rotate_i ? {shift_in, shift_in} :
                                {{WORD_W{fill_bit}}, shift_in};

  //////////////////////////////////////////////////////////////////////
  // shift and output side
  //////////////////////////////////////////////////////////////////////

  assign shift_wide  = shift_src >> shamt_i;
  assign shift_right = shift_wide[WORD_W-1:0];

  // undo the input reversal for left shifts
  assign shift_right_rev = {<<{shift_right}};

  assign result_o = shift_left_i ? shift_right_rev : shift_right;

endmodule

`default_nettype wire

/* design/alu_top.sv */
// alu_top
// request/acknowledge ALU: handshake unit around the combinational core

`timescale 1ns/10ps
`default_nettype none

module alu_top
(
  input  logic                   clk,
  input  logic                   rst_n_i,
  // requester side
  input  logic                   req_i,
  input  alu_data_pkg::alu_req_t req_data_i,
  output logic                   ack_o,
  output alu_data_pkg::alu_rsp_t rsp_o
);

  // registered operands toward the core
  alu_data_pkg::alu_req_t core_req;
  // combinational result back from the core
  alu_data_pkg::alu_rsp_t core_rsp;

  alu_req_ack u_req_ack
  (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o),
    .core_req_o (core_req),
    .core_rsp_i (core_rsp)
  );

  alu_core u_core
  (
    .req_i (core_req),
    .rsp_o (core_rsp)
  );

endmodule

`default_nettype wire

/* testbench/alu_props.sv */
// alu_props
// concurrent handshake assertions, bound into alu_req_ack
// reset value, ack latency, ack hold, response stability, ack release

`timescale 1ns/10ps
`default_nettype none

module alu_props
(
  input logic                    clk,
  input logic                    rst_n_i,
  input logic                    req_i,
  input logic                    ack_i,
  input alu_data_pkg::alu_rsp_t  rsp_i,
  input alu_data_pkg::hs_state_e state_i
);

  // number of failed assertions, read by the testbench at the end
  int unsigned fail_count = 0;

  //////////////////////////////////////////////////////////////////////
  // reset
  //////////////////////////////////////////////////////////////////////

  // covers every reset cycle and the first cycle after release
  a_ack_low_in_reset: assert property (@(posedge clk) !rst_n_i |=> !ack_i)
  else
  begin
    $error("ack high during or right after reset");
    fail_count++;
  end

  //////////////////////////////////////////////////////////////////////
  // handshake timing
  //////////////////////////////////////////////////////////////////////

  // capture edge, then one BUSY cycle, then ack
  a_ack_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_i == alu_data_pkg::IDLE) && req_i |=> !ack_i ##1 ack_i)
  else
  begin
    $error("ack did not rise two edges after capture");
    fail_count++;
  end

  // back-pressure keeps the unit in DONE
  a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    ack_i && req_i |=> ack_i)
  else
  begin
    $error("ack dropped while req still high");
    fail_count++;
  end

  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    ack_i |=> (!ack_i || $stable(rsp_i)))
  else
  begin
    $error("response changed while ack high");
    fail_count++;
  end

  a_ack_release: assert property (@(posedge clk) disable iff (!rst_n_i)
    ack_i && !req_i |=> !ack_i)
  else
  begin
    $error("ack still high after req sampled low");
    fail_count++;
  end

endmodule

`default_nettype wire

/* testbench/alu_tb.sv */
// alu_tb
// clock, reset and a four-phase requester driving alu_top
// reference model of the operator rules
// directed corners, random operands and back-pressure runs

`timescale 1ns/10ps
`default_nettype none

module alu_tb;

  // cycles allowed for each wait
  localparam int TIMEOUT = 50;

  logic                   clk;
  logic                   rst_n_i;
  logic                   req_i;
  alu_data_pkg::alu_req_t req_data_i;
  logic                   ack_o;
  alu_data_pkg::alu_rsp_t rsp_o;

  int seed;
  int checks;
  int errors;
  int timeouts;
  int total;

  alu_top dut
  (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o)
  );

  // handshake assertions live next to the FSM
  bind alu_req_ack alu_props u_props
  (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (req_i),
    .ack_i   (ack_o),
    .rsp_i   (rsp_o),
    .state_i (state_q)
  );

  // 8 ns period
  always #4 clk = ~clk;

  function automatic alu_data_pkg::word_t rand_word();
    return alu_data_pkg::word_t'($random(seed));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic alu_data_pkg::alu_rsp_t model_rsp(alu_data_pkg::alu_req_t r);
    alu_data_pkg::alu_rsp_t rsp;
    alu_data_pkg::word_t    a;
    alu_data_pkg::word_t    b;
    int                     sh;
    logic                   lt_s;
    logic                   lt_u;
    logic                   eq;
    logic                   t;
    a    = r.operand_a;
    b    = r.operand_b;
    sh   = b[4:0];
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    eq   = (a == b);
    rsp  = '0;
    // truth value of the compare and slt operators
    case (r.operator)
      alu_op_pkg::EQ:   t = eq;
      alu_op_pkg::NE:   t = !eq;
      alu_op_pkg::GTS:  t = !lt_s && !eq;
      alu_op_pkg::GTU:  t = !lt_u && !eq;
      alu_op_pkg::GES:  t = !lt_s;
      alu_op_pkg::GEU:  t = !lt_u;
      alu_op_pkg::LTS:  t = lt_s;
      alu_op_pkg::LTU:  t = lt_u;
      alu_op_pkg::LES:  t = lt_s || eq;
      alu_op_pkg::LEU:  t = lt_u || eq;
      alu_op_pkg::SLTS: t = lt_s;
      alu_op_pkg::SLTU: t = lt_u;
      default:          t = 1'b0;
    endcase
    case (r.operator)
      alu_op_pkg::ADD:  rsp.result = a + b;
      alu_op_pkg::SUB:  rsp.result = a - b;
      // most negative value wraps to itself
      alu_op_pkg::ABS:  rsp.result = a[31] ? -a : a;
      alu_op_pkg::AND:  rsp.result = a & b;
      alu_op_pkg::OR:   rsp.result = a | b;
      alu_op_pkg::XOR:  rsp.result = a ^ b;
      alu_op_pkg::SLL:  rsp.result = a << sh;
      alu_op_pkg::SRL:  rsp.result = a >> sh;
      alu_op_pkg::SRA:  rsp.result = $signed(a) >>> sh;
      alu_op_pkg::ROR:  rsp.result = (a >> sh) | (a << (32 - sh));
      alu_op_pkg::MIN:  rsp.result = lt_s ? a : b;
      alu_op_pkg::MINU: rsp.result = lt_u ? a : b;
      alu_op_pkg::MAX:  rsp.result = lt_s ? b : a;
      alu_op_pkg::MAXU: rsp.result = lt_u ? b : a;
      alu_op_pkg::SLTS, alu_op_pkg::SLTU:
      begin
        rsp.result     = {31'b0, t};
        rsp.comparison = t;
      end
      default:
      begin
        // all ten word compares
        rsp.result     = {32{t}};
        rsp.comparison = t;
      end
    endcase
    return rsp;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // one four-phase transaction
  //////////////////////////////////////////////////////////////////////

  // hold = extra cycles that req stays high after ack
  task automatic run_txn(input string name, input alu_op_pkg::alu_op_e op,
                         input alu_data_pkg::word_t a, input alu_data_pkg::word_t b,
                         input int hold);
    alu_data_pkg::alu_req_t req;
    alu_data_pkg::alu_rsp_t exp;
    int                     cycles;
    req.operator  = op;
    req.operand_a = a;
    req.operand_b = b;
    exp = model_rsp(req);
    @(posedge clk);
    req_i      <= 1'b1;
    req_data_i <= req;
    // outputs sampled on the falling edge
    cycles = 0;
    @(negedge clk);
    while (!ack_o && cycles < TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!ack_o)
    begin
      $display("timeout: no acknowledge for %s %s", name, op.name());
      timeouts++;
    end
    else
    begin
      checks++;
      assert (rsp_o === exp)
      else
      begin
        $display("Error %s %s a=%h b=%h: expected %h/%b actual %h/%b", name, op.name(),
                 a, b, exp.result, exp.comparison, rsp_o.result, rsp_o.comparison);
        errors++;
      end
      // response must not move under back-pressure
      for (int i = 0; i < hold; i++)
      begin
        @(negedge clk);
        checks++;
        assert (ack_o && rsp_o === exp)
        else
        begin
          $display("Error %s %s hold cycle %0d: expected %h/%b actual %h/%b ack %b", name,
                   op.name(), i, exp.result, exp.comparison, rsp_o.result,
                   rsp_o.comparison, ack_o);
          errors++;
        end
      end
    end
    @(posedge clk);
    req_i <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (ack_o && cycles < TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (ack_o)
    begin
      $display("timeout: acknowledge never dropped after %s %s", name, op.name());
      timeouts++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial
  begin : main
    alu_data_pkg::word_t corners [4];
    alu_data_pkg::word_t a;
    alu_data_pkg::word_t b;
    int                  hold;
    seed       = 56;
    checks     = 0;
    errors     = 0;
    timeouts   = 0;
    clk        = 1'b0;
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    req_data_i = '0;
    corners    = '{32'h0000_0000, 32'h0000_0001, 32'h8000_0000, 32'hffff_ffff};
    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;

    // ack low and response register cleared out of reset
    @(negedge clk);
    checks++;
    assert (!ack_o && rsp_o === '0)
    else
    begin
      $display("Error reset: expected ack 0 rsp %h actual ack %b rsp %h", 33'h0, ack_o,
               rsp_o);
      errors++;
    end

    // arithmetic corners and random operands
    foreach (corners[i])
    begin
      run_txn("abs corner", alu_op_pkg::ABS, corners[i], rand_word(), 0);
      foreach (corners[j])
      begin
        run_txn("add corner", alu_op_pkg::ADD, corners[i], corners[j], 0);
        run_txn("sub corner", alu_op_pkg::SUB, corners[i], corners[j], 0);
      end
    end
    repeat (10)
    begin
      a = rand_word();
      b = rand_word();
      run_txn("add random", alu_op_pkg::ADD, a, b, 0);
      run_txn("sub random", alu_op_pkg::SUB, a, b, 0);
      run_txn("abs random", alu_op_pkg::ABS, a, b, 0);
    end

    // logic and shifts
    // upper bits of b must not affect a shift
    for (int k = alu_op_pkg::AND; k <= alu_op_pkg::ROR; k++)
    begin
      repeat (8)
        run_txn("logic/shift random", alu_op_pkg::alu_op_e'(k), rand_word(), rand_word(), 0);
      run_txn("amount 0", alu_op_pkg::alu_op_e'(k), rand_word(), rand_word() & ~32'h1f, 0);
      run_txn("amount 31", alu_op_pkg::alu_op_e'(k), rand_word(), rand_word() | 32'h1f, 0);
    end

    // compares and set-less-than
    for (int k = alu_op_pkg::EQ; k <= alu_op_pkg::SLTU; k++)
    begin
      repeat (6)
        run_txn("compare random", alu_op_pkg::alu_op_e'(k), rand_word(), rand_word(), 0);
      a = rand_word();
      run_txn("compare equal", alu_op_pkg::alu_op_e'(k), a, a, 0);
      // only the top lane's sign bit differs
      run_txn("compare sign", alu_op_pkg::alu_op_e'(k), a, a ^ 32'h8000_0000, 0);
      run_txn("compare sign", alu_op_pkg::alu_op_e'(k), a ^ 32'h8000_0000, a, 0);
    end

    // min and max
    for (int k = alu_op_pkg::MIN; k <= alu_op_pkg::MAXU; k++)
    begin
      repeat (6)
        run_txn("minmax random", alu_op_pkg::alu_op_e'(k), rand_word(), rand_word(), 0);
      a = rand_word() & 32'h7fff_ffff;
      b = rand_word() | 32'h8000_0000;
      run_txn("minmax sign", alu_op_pkg::alu_op_e'(k), a, b, 0);
      run_txn("minmax sign", alu_op_pkg::alu_op_e'(k), b, a, 0);
    end

    // back-pressure with requests back to back
    repeat (16)
    begin
      hold = $unsigned($random(seed)) % 11;
      run_txn("back-pressure", alu_op_pkg::alu_op_e'($unsigned($random(seed)) % 26),
              rand_word(), rand_word(), hold);
    end

    repeat (2) @(posedge clk);
    total = errors + timeouts + dut.u_req_ack.u_props.fail_count;
    $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, dut.u_req_ack.u_props.fail_count);
    if (total == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire
